//--- src.f
src/sv32_pkg.sv
src/page_table_walker.sv
src/tlb.sv
src/translation_unit.sv
testbench/page_table_mem.sv
testbench/tb_translation_unit.sv

//--- Makefile
TOP := tb_translation_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "Done: no errors" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_translation_unit.sv
// Translation unit testbench; root PPN fixed at 1, L2 table at PPN 2, checks are assertions at done
`timescale 1ns/100ps
`default_nettype none

module tb_translation_unit import sv32_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        req;
    logic [31:0] vaddr;
    access_t     access;
    privilege_t  priv;
    logic        sum;
    logic        mxr;
    logic [19:0] root_ppn;
    logic        flush;
    logic        ready;
    logic        done;
    logic        fault;
    logic [31:0] paddr;
    logic        mem_request;
    logic [31:0] mem_addr;
    logic        mem_ack;
    logic        mem_rdata_valid;
    logic [31:0] mem_rdata;

    // Expected result of the request in flight
    logic        exp_hit;
    logic        exp_fault;
    logic [31:0] exp_paddr;
    int          exp_reads;
    logic [31:0] exp_l1_addr;               // Expected PTE read addresses
    logic [31:0] exp_l2_addr;

    // Shadow TLB, round robin like the DUT
    logic        sh_valid [TLB_ENTRIES];
    logic [19:0] sh_vpn   [TLB_ENTRIES];
    logic [19:0] sh_ppn   [TLB_ENTRIES];
    logic [31:0] sh_pte   [TLB_ENTRIES];
    int          sh_next;

    int          cyc;                       // Cycles since req
    int          reads;                     // Acks since req
    logic        pending;
    logic        outstanding;               // Ack seen, data not yet
    int          cycles = 0;
    int          cycle_limit = 40 * 35 * 25;    // 40 x requests x worst walk

    translation_unit dut (.*);

    page_table_mem mem_model (
        .clk             (clk),
        .rst             (rst),
        .mem_request     (mem_request),
        .mem_addr        (mem_addr),
        .mem_ack         (mem_ack),
        .mem_rdata_valid (mem_rdata_valid),
        .mem_rdata       (mem_rdata)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////
    // Failure reporting
    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("ERROR %s: got 0x%h, expected 0x%h", name, got, want);
        $display("Done: errors found");
        $fatal(1, "value check failed");
    endtask

    task automatic protocol_violation(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "protocol check failed");
    endtask

    ////////////////////////////////////////////////////////////////////
    // Reference model
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return mem_model.words[addr[13:2]];
    endfunction

    function automatic logic allowed(input logic [31:0] pte, input access_t acc,
                                     input privilege_t prv, input logic s, input logic m);
        logic kind_ok;
        logic level_ok;
        case (acc)
            ACCESS_FETCH: kind_ok = pte[PTE_X];
            ACCESS_STORE: kind_ok = pte[PTE_W] & pte[PTE_D];
            default:      kind_ok = pte[PTE_R] | (pte[PTE_X] & m);  // Load
        endcase
        case (prv)
            USER_PRIV:       level_ok = pte[PTE_U];
            SUPERVISOR_PRIV: level_ok = ~pte[PTE_U] | s;
            default:         level_ok = 1'b1;
        endcase
        return pte[PTE_A] & kind_ok & level_ok;     // A always required
    endfunction

    task automatic predict(input logic [31:0] va, input access_t acc, input privilege_t prv,
                           input logic s, input logic m);
        logic [31:0] pte1;
        logic [31:0] pte2;
        logic [31:0] leaf;
        logic [19:0] page;
        logic        bad;
        int          idx;
        exp_hit = 1'b0;
        idx     = 0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (sh_valid[i] && sh_vpn[i] == va[31:12]) begin
                exp_hit = 1'b1;
                idx     = i;
            end
        end
        if (exp_hit) begin
            exp_reads = 0;
            exp_fault = !allowed(sh_pte[idx], acc, prv, s, m);
            exp_paddr = {sh_ppn[idx], va[11:0]};
        end else begin
            exp_l1_addr = {root_ppn, va[31:22], 2'b00};
            pte1        = read_word(exp_l1_addr);
            exp_reads   = 1;
            leaf        = pte1;
            page        = {pte1[29:20], va[21:12]};     // Superpage keeps VPN0
            bad         = !pte1[PTE_V] || (pte1[PTE_W] && !pte1[PTE_R]);
            if (!bad && !pte1[PTE_R] && !pte1[PTE_X]) begin
                exp_l2_addr = {pte1[29:10], va[21:12], 2'b00};
                pte2        = read_word(exp_l2_addr);
                exp_reads   = 2;
                leaf        = pte2;
                page        = pte2[29:10];
                bad         = !pte2[PTE_V] || (pte2[PTE_W] && !pte2[PTE_R]) ||
                              !(pte2[PTE_R] || pte2[PTE_X]);  // No level three
            end
            exp_fault = bad || !allowed(leaf, acc, prv, s, m);
            exp_paddr = {page, va[11:0]};
            if (!exp_fault) begin
                sh_valid[sh_next] = 1'b1;
                sh_vpn[sh_next]   = va[31:12];
                sh_ppn[sh_next]   = page;
                sh_pte[sh_next]   = leaf;
                sh_next           = (sh_next + 1) % TLB_ENTRIES;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    function automatic logic [31:0] virt_addr(input logic [9:0] vpn1, input logic [9:0] vpn0,
                                              input logic [11:0] offset);
        return {vpn1, vpn0, offset};
    endfunction

    task automatic set_pte(input logic [19:0] table_ppn, input logic [9:0] index,
                           input logic [19:0] ppn, input logic [7:0] flags);
        mem_model.words[{table_ppn[1:0], index}] = {2'b00, ppn, 2'b00, flags};
    endtask

    task automatic translate(input logic [31:0] va, input access_t acc, input privilege_t prv,
                             input logic s, input logic m);
        predict(va, acc, prv, s, m);
        vaddr  = va;
        access = acc;
        priv   = prv;
        sum    = s;
        mxr    = m;
        req    = 1'b1;
        @(negedge clk);
        req = 1'b0;
        while (!done) @(negedge clk);
        @(negedge clk);             // Checks sample done before inputs move
    endtask

    task automatic flush_tlb();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) sh_valid[i] = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Monitors and checks
    always @(posedge clk) begin
        if (rst) begin
            cyc         <= 0;
            reads       <= 0;
            pending     <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            cyc <= req ? 1 : cyc + 1;
            if (req) reads <= 0;
            else if (mem_ack) reads <= reads + 1;
            if (req) pending <= 1'b1;
            else if (done) pending <= 1'b0;
            if (mem_ack) outstanding <= 1'b1;
            else if (mem_rdata_valid) outstanding <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) protocol_violation("Timeout, translation never completed");
    end

    check_fault: assert property (@(posedge clk) disable iff (rst) done |-> fault == exp_fault)
        else value_mismatch("fault", 32'(fault), 32'(exp_fault));
    check_paddr: assert property (@(posedge clk) disable iff (rst)
        (done && !exp_fault) |-> paddr == exp_paddr)
        else value_mismatch("paddr", paddr, exp_paddr);
    check_reads: assert property (@(posedge clk) disable iff (rst) done |-> reads == exp_reads)
        else value_mismatch("mem reads", 32'($sampled(reads)), 32'(exp_reads));
    check_addr: assert property (@(posedge clk) disable iff (rst)
        mem_ack |-> mem_addr == ((reads == 0) ? exp_l1_addr : exp_l2_addr))
        else value_mismatch("mem_addr", mem_addr,
                            ($sampled(reads) == 0) ? exp_l1_addr : exp_l2_addr);
    check_hit_latency: assert property (@(posedge clk) disable iff (rst)
        (done && exp_hit) |-> cyc == 1)
        else value_mismatch("hit latency", 32'($sampled(cyc)), 32'd1);
    check_done_owner: assert property (@(posedge clk) disable iff (rst) done |-> pending)
        else protocol_violation("done arrived with no request in flight");
    check_busy: assert property (@(posedge clk) disable iff (rst) (pending && !done) |-> !ready)
        else protocol_violation("ready went high before the walk finished");
    check_idle_ready: assert property (@(posedge clk) disable iff (rst) !pending |-> ready)
        else protocol_violation("ready low with no request in flight");
    check_idle_quiet: assert property (@(posedge clk) disable iff (rst) !pending |-> !mem_request)
        else protocol_violation("memory read started with no request in flight");
    check_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_request && !mem_ack) |=> mem_request)
        else protocol_violation("mem_request dropped before mem_ack");
    check_one_read: assert property (@(posedge clk) disable iff (rst)
        outstanding |-> !mem_request)
        else protocol_violation("new memory read started while a response was outstanding");

    ////////////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        req      = 1'b0;
        vaddr    = '0;
        access   = ACCESS_LOAD;
        priv     = SUPERVISOR_PRIV;
        sum      = 1'b0;
        mxr      = 1'b0;
        root_ppn = 20'h00001;
        flush    = 1'b0;
        sh_next  = 0;
        for (int i = 0; i < TLB_ENTRIES; i++) sh_valid[i] = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Level one table, flags are D A G U X W R V
        set_pte(20'h1, 10'd0, 20'h00002, 8'h01);    // Pointer
        set_pte(20'h1, 10'd1, 20'h55400, 8'hc7);    // Superpage
        set_pte(20'h1, 10'd2, 20'h00000, 8'h00);    // Invalid
        set_pte(20'h1, 10'd3, 20'h00007, 8'h05);    // W without R
        // Level two table
        set_pte(20'h2, 10'd0, 20'h40000, 8'hc7);    // Supervisor RW
        set_pte(20'h2, 10'd1, 20'h40001, 8'hdf);    // User RWX
        set_pte(20'h2, 10'd2, 20'h40002, 8'h47);    // D clear
        set_pte(20'h2, 10'd3, 20'h40003, 8'hc3);    // Read only
        set_pte(20'h2, 10'd4, 20'h40004, 8'h49);    // Execute only
        set_pte(20'h2, 10'd5, 20'h40005, 8'h87);    // A clear
        set_pte(20'h2, 10'd6, 20'h00003, 8'h01);    // Pointer at level two
        set_pte(20'h2, 10'd7, 20'h00000, 8'h00);
        set_pte(20'h2, 10'd8, 20'h40008, 8'h45);
        for (int p = 9; p < 14; p++) set_pte(20'h2, 10'(p), 20'(20'h40000 + p), 8'hc7);

        // Walks, hits and the fault cases
        translate(virt_addr(10'd0, 10'd0, 12'h123), ACCESS_STORE, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd0, 12'h456), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd0, 12'h789), ACCESS_FETCH, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd1, 12'h010), ACCESS_FETCH, USER_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd1, 10'h2a, 12'h9ab), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd1, 10'h3ff, 12'hfff), ACCESS_STORE, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd2, 10'd0, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd3, 10'd0, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd6, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd7, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd8, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd5, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd2, 12'h000), ACCESS_STORE, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd2, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd2, 12'h004), ACCESS_STORE, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd3, 12'h000), ACCESS_STORE, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd4, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd4, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b1);
        translate(virt_addr(10'd0, 10'd1, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd0, 10'd1, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b1, 1'b0);
        translate(virt_addr(10'd0, 10'd0, 12'h000), ACCESS_LOAD, USER_PRIV, 1'b0, 1'b0);
        translate(virt_addr(10'd2, 10'd0, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);

        // Stale entry survives a table change until flush
        flush_tlb();
        translate(virt_addr(10'd0, 10'd9, 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        set_pte(20'h2, 10'd9, 20'h4ff09, 8'hc7);
        translate(virt_addr(10'd0, 10'd9, 12'habc), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);
        flush_tlb();
        translate(virt_addr(10'd0, 10'd9, 12'habc), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);

        // Five pages into four entries, the first one is evicted
        flush_tlb();
        for (int p = 9; p < 14; p++) begin
            translate(virt_addr(10'd0, 10'(p), 12'h000), ACCESS_LOAD, SUPERVISOR_PRIV,
                      1'b0, 1'b0);
        end
        for (int p = 10; p < 14; p++) begin
            translate(virt_addr(10'd0, 10'(p), 12'h020), ACCESS_LOAD, SUPERVISOR_PRIV,
                      1'b0, 1'b0);
        end
        translate(virt_addr(10'd0, 10'd9, 12'h040), ACCESS_LOAD, SUPERVISOR_PRIV, 1'b0, 1'b0);

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/page_table_mem.sv
// PTE memory model, 4096 words indexed by addr[13:2]; one read at a time, random ack and data delays
`timescale 1ns/100ps
`default_nettype none

module page_table_mem (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        mem_request,
    input  wire logic [31:0] mem_addr,
    output logic             mem_ack,
    output logic             mem_rdata_valid,
    output logic [31:0]      mem_rdata
);

    logic [31:0] words [4096];     // Written by the testbench through hierarchy
    logic [11:0] read_idx;
    int          seed;
    int          ack_wait;
    int          data_wait;

    initial begin
        seed            = 32'h8e37_bcc5;
        mem_ack         = 1'b0;
        mem_rdata_valid = 1'b0;
        mem_rdata       = '0;
        for (int i = 0; i < 4096; i++) begin
            words[i] = (i << 2) ^ 32'hdead_0000;    // V clear, differs per address
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Read responder, driven on the falling edge
    always begin
        @(negedge clk);
        if (mem_request && !rst) begin
            ack_wait  = {$random(seed)} % 4;        // 0-3 cycles to ack
            data_wait = {$random(seed)} % 4 + 1;    // 1-4 cycles to data
            repeat (ack_wait) @(negedge clk);
            read_idx = mem_addr[13:2];
            mem_ack  = 1'b1;
            @(negedge clk);
            mem_ack = 1'b0;
            repeat (data_wait - 1) @(negedge clk);
            mem_rdata       = words[read_idx];
            mem_rdata_valid = 1'b1;
            @(negedge clk);
            mem_rdata_valid = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/translation_unit.sv
// Sv32 translation top; single requester, walker owns the memory read port directly
`timescale 1ns/100ps
`default_nettype none

module translation_unit import sv32_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    // Request side
    input  wire logic        req,
    input  wire logic [31:0] vaddr,
    input  wire access_t     access,
    input  wire privilege_t  priv,
    input  wire logic        sum,
    input  wire logic        mxr,
    input  wire logic [19:0] root_ppn,
    input  wire logic        flush,
    output logic             ready,
    output logic             done,
    output logic             fault,
    output logic [31:0]      paddr,
    // Memory side
    output logic             mem_request,
    output logic [31:0]      mem_addr,
    input  wire logic        mem_ack,
    input  wire logic        mem_rdata_valid,
    input  wire logic [31:0] mem_rdata
);

    ////////////////////////////////////////////////////////////////////
    // TLB to walker
    logic              walk_start;
    logic              walk_done;
    logic              walk_fault;
    logic [19:0]       walk_ppn;
    logic [PERM_W-1:0] walk_perm;

    tlb u_tlb (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .vaddr      (vaddr),
        .access     (access),
        .priv       (priv),
        .sum        (sum),
        .mxr        (mxr),
        .flush      (flush),
        .walk_done  (walk_done),
        .walk_fault (walk_fault),
        .walk_ppn   (walk_ppn),
        .walk_perm  (walk_perm),
        .ready      (ready),
        .done       (done),
        .fault      (fault),
        .paddr      (paddr),
        .walk_start (walk_start)
    );

    page_table_walker u_walker (
        .clk             (clk),
        .rst             (rst),
        .walk_start      (walk_start),
        .vaddr           (vaddr),      // Held stable by requester until done
        .access          (access),
        .priv            (priv),
        .sum             (sum),
        .mxr             (mxr),
        .root_ppn        (root_ppn),
        .mem_ack         (mem_ack),
        .mem_rdata_valid (mem_rdata_valid),
        .mem_rdata       (mem_rdata),
        .mem_request     (mem_request),
        .mem_addr        (mem_addr),
        .walk_done       (walk_done),
        .walk_fault      (walk_fault),
        .walk_ppn        (walk_ppn),
        .walk_perm       (walk_perm)
    );

endmodule

`default_nettype wire

//--- src/tlb.sv
// Four-entry fully associative TLB; no ASIDs or global pages, faults are never cached
`timescale 1ns/100ps
`default_nettype none

module tlb import sv32_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              req,
    input  wire logic [31:0]       vaddr,
    input  wire access_t           access,
    input  wire privilege_t        priv,
    input  wire logic              sum,
    input  wire logic              mxr,
    input  wire logic              flush,
    input  wire logic              walk_done,
    input  wire logic              walk_fault,
    input  wire logic [19:0]       walk_ppn,
    input  wire logic [PERM_W-1:0] walk_perm,
    output logic                   ready,
    output logic                   done,
    output logic                   fault,
    output logic [31:0]            paddr,
    output logic                   walk_start
);

    // Entry storage
    logic [TLB_ENTRIES-1:0] valid;
    logic [19:0]            tag  [TLB_ENTRIES];
    logic [19:0]            ppn  [TLB_ENTRIES];
    logic [PERM_W-1:0]      perm [TLB_ENTRIES];

    logic [TLB_IDX_W-1:0]   rr_ptr;     // Next victim

    logic [TLB_ENTRIES-1:0] match;
    logic                   hit;
    logic [19:0]            hit_ppn;
    logic [PERM_W-1:0]      hit_perm;
    logic                   lookup;

    assign lookup = req & ready;

    ////////////////////////////////////////////////////////////////////
    // Parallel tag compare
    always_comb begin
        hit_ppn  = '0;
        hit_perm = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = valid[i] & (tag[i] == vaddr[31:12]);
            if (match[i]) begin
                hit_ppn  = hit_ppn | ppn[i];     // One-hot match, OR is a mux
                hit_perm = hit_perm | perm[i];
            end
        end
    end
    assign hit = |match;

    ////////////////////////////////////////////////////////////////////
    // Control: ready, done, fault, walk start
    always_ff @(posedge clk) begin
        if (rst) begin
            ready      <= 1'b1;
            done       <= 1'b0;
            fault      <= 1'b0;
            walk_start <= 1'b0;
        end else begin
            done       <= 1'b0;
            walk_start <= 1'b0;
            if (lookup) begin
                if (hit) begin
                    done  <= 1'b1;
                    fault <= ~perm_ok(hit_perm, access, priv, sum, mxr);   // Recheck on hit
                end else begin
                    walk_start <= 1'b1;
                    ready      <= 1'b0;     // Hold off until walk ends
                end
            end else if (walk_done | walk_fault) begin
                done  <= 1'b1;
                fault <= walk_fault;
                ready <= 1'b1;
            end
        end
    end

    // Physical address, hit or walk result
    always_ff @(posedge clk) begin
        if (lookup & hit) begin
            paddr <= {hit_ppn, vaddr[11:0]};
        end else if (walk_done) begin
            paddr <= {walk_ppn, vaddr[11:0]};
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Valid bits and round-robin pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            valid  <= '0;
            rr_ptr <= '0;
        end else if (flush & ready) begin
            valid <= '0;                    // Whole-TLB invalidate
        end else if (walk_done) begin
            valid[rr_ptr] <= 1'b1;
            rr_ptr        <= rr_ptr + 1'b1;
        end
    end

    // Entry payload, written only by a successful walk
    always_ff @(posedge clk) begin
        if (walk_done) begin
            tag[rr_ptr]  <= vaddr[31:12];
            ppn[rr_ptr]  <= walk_ppn;
            perm[rr_ptr] <= walk_perm;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Assertions
    single_match: assert property (@(posedge clk) disable iff (rst)
        req |-> $onehot0(match))
        else $error("more than one TLB entry matches the same VPN");

    req_while_busy: assert property (@(posedge clk) disable iff (rst)
        req |-> ready)
        else $error("translation request while TLB busy with a walk");

endmodule

`default_nettype wire

//--- src/page_table_walker.sv
// Two-level Sv32 walker; one read outstanding, request inputs must hold stable for the whole walk
`timescale 1ns/100ps
`default_nettype none

module page_table_walker import sv32_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              walk_start,
    input  wire logic [31:0]       vaddr,
    input  wire access_t           access,
    input  wire privilege_t        priv,
    input  wire logic              sum,
    input  wire logic              mxr,
    input  wire logic [19:0]       root_ppn,
    input  wire logic              mem_ack,
    input  wire logic              mem_rdata_valid,
    input  wire logic [31:0]       mem_rdata,
    output logic                   mem_request,
    output logic [31:0]            mem_addr,
    output logic                   walk_done,
    output logic                   walk_fault,
    output logic [19:0]            walk_ppn,
    output logic [PERM_W-1:0]      walk_perm
);

    walk_state_t state;
    walk_state_t next_state;

    logic pte_bad;      // Invalid or reserved w-without-r
    logic pte_leaf;     // r or x set
    logic leaf_ok;

    ////////////////////////////////////////////////////////////////////
    // PTE decode, straight off the read data
    assign pte_bad  = ~mem_rdata[PTE_V] | (mem_rdata[PTE_W] & ~mem_rdata[PTE_R]);
    assign pte_leaf = mem_rdata[PTE_R] | mem_rdata[PTE_X];
    assign leaf_ok  = perm_ok(pte_perm(mem_rdata), access, priv, sum, mxr);

    ////////////////////////////////////////////////////////////////////
    // Memory port
    assign mem_request = (state == SEND_L1) | (state == SEND_L2);

    always_ff @(posedge clk) begin
        if (state == WALK_IDLE) begin
            mem_addr <= {root_ppn, vaddr[31:22], 2'b00};   // Level one PTE
        end else if ((state == WAIT_L1) & mem_rdata_valid) begin
            mem_addr <= {mem_rdata[PTE_PPN1_LSB +: 10], mem_rdata[PTE_PPN0_LSB +: 10],
                         vaddr[21:12], 2'b00};              // Level two PTE
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Walk FSM
    always_comb begin
        next_state = state;
        unique case (state)
            WALK_IDLE:
                if (walk_start) next_state = SEND_L1;
            SEND_L1:
                if (mem_ack) next_state = WAIT_L1;
            WAIT_L1:
                if (mem_rdata_valid) begin
                    if (pte_bad)
                        next_state = WALK_FAULT;
                    else if (pte_leaf)  // Superpage
                        next_state = leaf_ok ? WALK_DONE : WALK_FAULT;
                    else
                        next_state = SEND_L2;   // Pointer
                end
            SEND_L2:
                if (mem_ack) next_state = WAIT_L2;
            WAIT_L2:
                if (mem_rdata_valid) begin
                    // No third level, so a pointer here is a fault
                    if (pte_bad | ~pte_leaf)
                        next_state = WALK_FAULT;
                    else
                        next_state = leaf_ok ? WALK_DONE : WALK_FAULT;
                end
            WALK_DONE, WALK_FAULT:
                next_state = WALK_IDLE;
            default:
                next_state = WALK_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WALK_IDLE;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Result back to the TLB
    always_ff @(posedge clk) begin
        if (mem_rdata_valid) begin
            walk_ppn[19:10] <= mem_rdata[PTE_PPN1_LSB +: 10];
            walk_ppn[9:0]   <= (state == WAIT_L2) ? mem_rdata[PTE_PPN0_LSB +: 10]
                                                  : vaddr[21:12];   // Superpage keeps VPN0
            walk_perm       <= pte_perm(mem_rdata);
        end
    end

    assign walk_done  = (state == WALK_DONE);
    assign walk_fault = (state == WALK_FAULT);

    ////////////////////////////////////////////////////////////////////
    // Assertions
    spurious_response: assert property (@(posedge clk) disable iff (rst)
        mem_rdata_valid |-> ((state == WAIT_L1) | (state == WAIT_L2)))
        else $error("walker got read data with no read outstanding");

    request_held: assert property (@(posedge clk) disable iff (rst)
        (mem_request & ~mem_ack) |=> mem_request)
        else $error("walker dropped mem_request before ack");

endmodule

`default_nettype wire

//--- src/sv32_pkg.sv
// Sv32 shared definitions; A and D bits are software managed, G bit and upper PPN1 bits are ignored
`default_nettype none

package sv32_pkg;

    ////////////////////////////////////////////////////////////////////
    // Privilege and access kinds
    typedef enum logic [1:0] {
        USER_PRIV       = 2'b00,
        SUPERVISOR_PRIV = 2'b01,
        MACHINE_PRIV    = 2'b11
    } privilege_t;

    typedef enum logic [1:0] {
        ACCESS_LOAD  = 2'b00,
        ACCESS_STORE = 2'b01,
        ACCESS_FETCH = 2'b10
    } access_t;

    // Walker FSM, one-hot
    typedef enum logic [6:0] {
        WALK_IDLE  = 7'b0000001,
        SEND_L1    = 7'b0000010,
        WAIT_L1    = 7'b0000100,
        SEND_L2    = 7'b0001000,
        WAIT_L2    = 7'b0010000,
        WALK_DONE  = 7'b0100000,
        WALK_FAULT = 7'b1000000
    } walk_state_t;

    ////////////////////////////////////////////////////////////////////
    // PTE layout
    localparam int PTE_V = 0;
    localparam int PTE_R = 1;
    localparam int PTE_W = 2;
    localparam int PTE_X = 3;
    localparam int PTE_U = 4;
    localparam int PTE_A = 6;           // bit 5 is G, unused
    localparam int PTE_D = 7;
    localparam int PTE_PPN0_LSB = 10;
    localparam int PTE_PPN1_LSB = 20;   // only low 10 bits used

    // Stored permission vector {d, a, u, x, w, r}
    localparam int PERM_W = 6;

    localparam int TLB_ENTRIES = 4;
    localparam int TLB_IDX_W = $clog2(TLB_ENTRIES);

    // Pack PTE permission bits into the stored vector
    function automatic logic [PERM_W-1:0] pte_perm(input logic [31:0] pte);
        return {pte[PTE_D], pte[PTE_A], pte[PTE_U], pte[PTE_X], pte[PTE_W], pte[PTE_R]};
    endfunction

    // Access and privilege check, shared by walker and TLB hit path
    function automatic logic perm_ok(
        input logic [PERM_W-1:0] perm,
        input access_t           acc,
        input privilege_t        prv,
        input logic              sum,
        input logic              mxr
    );
        logic r;
        logic w;
        logic x;
        logic u;
        logic a;
        logic d;
        logic acc_ok;
        logic prv_ok;
        {d, a, u, x, w, r} = perm;
        acc_ok = ((acc == ACCESS_FETCH) & x & a) |
                 ((acc == ACCESS_LOAD) & (r | (x & mxr)) & a) |
                 ((acc == ACCESS_STORE) & w & a & d);       // D must already be set
        prv_ok = (prv == MACHINE_PRIV) |
                 ((prv == SUPERVISOR_PRIV) & (~u | sum)) |
                 ((prv == USER_PRIV) & u);
        return acc_ok & prv_ok;
    endfunction

endpackage

`default_nettype wire
